// File: logic/best_select.sv
`timescale 1ns/1ps

module best_select #(
    parameter int N_POINTS = 40
) (
    input  logic                CLK,
    input  logic                RST,
    input  logic                result_valid,
    input  laser_pkg::count_t   result_count,
    input  logic [N_POINTS-1:0] result_mask,
    input  laser_pkg::coord_t   result_x,
    input  laser_pkg::coord_t   result_y,
    input  logic                second_pass,
    input  logic                pass_end,
    output logic [N_POINTS-1:0] c1_mask,
    output laser_pkg::coord_t   c1_x,
    output laser_pkg::coord_t   c1_y,
    output laser_pkg::coord_t   c2_x,
    output laser_pkg::coord_t   c2_y,
    output logic                done
);

    logic                have_best;   // a result has been seen this pass
    logic                take;
    logic                p1_ended;
    laser_pkg::count_t   best_count;
    logic [N_POINTS-1:0] best_mask;
    laser_pkg::coord_t   best_x;
    laser_pkg::coord_t   best_y;
    laser_pkg::coord_t   hold_x;      // circle one, kept until report
    laser_pkg::coord_t   hold_y;

    // strictly greater, so the earliest center wins ties
    assign take = result_valid && (!have_best || result_count > best_count);

    always_ff @(posedge CLK) begin
        if (take) begin
            best_count <= result_count;
            best_mask  <= result_mask;
            best_x     <= result_x;
            best_y     <= result_y;
        end
        if (pass_end && !second_pass) begin
            c1_mask <= best_mask;
            hold_x  <= best_x;
            hold_y  <= best_y;
        end
    end

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            have_best <= 1'b0;
            p1_ended  <= 1'b0;
            done      <= 1'b0;
            c1_x      <= '0;
            c1_y      <= '0;
            c2_x      <= '0;
            c2_y      <= '0;
        end else begin
            done <= 1'b0;
            if (pass_end) begin
                have_best <= 1'b0;
            end else if (result_valid) begin
                have_best <= 1'b1;
            end

            if (pass_end && !second_pass) begin
                p1_ended <= 1'b1;
            end else if (done) begin
                p1_ended <= 1'b0;
            end

            if (pass_end && second_pass) begin   // all four move together
                c1_x <= hold_x;
                c1_y <= hold_y;
                c2_x <= best_x;
                c2_y <= best_y;
                done <= 1'b1;
            end
        end
    end

    a_done_after_pass1: assert property (
        @(posedge CLK) disable iff (RST)
        $rose(done) |-> p1_ended
    ) else $error("done raised without a finished first pass");

endmodule

// File: logic/cover_counter.sv
`timescale 1ns/1ps

module cover_counter #(
    parameter int N_POINTS = 40
) (
    input  logic                CLK,
    input  logic                RST,
    input  logic                scan_en,
    input  logic                second_pass,
    input  logic                last_point,
    input  laser_pkg::count_t   point_idx,
    input  laser_pkg::coord_t   cx,
    input  laser_pkg::coord_t   cy,
    input  laser_pkg::coord_t   px,
    input  laser_pkg::coord_t   py,
    input  logic [N_POINTS-1:0] c1_mask,
    output logic                result_valid,
    output laser_pkg::count_t   result_count,
    output logic [N_POINTS-1:0] result_mask,
    output laser_pkg::coord_t   result_x,
    output laser_pkg::coord_t   result_y
);

    laser_pkg::coord_t   dx;
    laser_pkg::coord_t   dy;
    laser_pkg::coord_t   d_big;
    laser_pkg::coord_t   d_small;
    logic                in_circle;
    logic                hit;
    logic [N_POINTS-1:0] hit_bit;
    laser_pkg::count_t   acc_count;
    logic [N_POINTS-1:0] acc_mask;

    assign dx      = (cx > px) ? cx - px : px - cx;
    assign dy      = (cy > py) ? cy - py : py - cy;
    assign d_big   = (dx > dy) ? dx : dy;
    assign d_small = (dx > dy) ? dy : dx;

    // dx^2 + dy^2 <= 16 on the integer grid
    assign in_circle = (d_big < 3) ||
                       (d_big == 3 && d_small < 3) ||
                       (d_big == 4 && d_small == 0);

    assign hit     = in_circle && !(second_pass && c1_mask[point_idx]);
    assign hit_bit = N_POINTS'(hit) << point_idx;

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            result_valid <= 1'b0;
            acc_count    <= '0;
            acc_mask     <= '0;
        end else begin
            result_valid <= last_point;
            if (last_point) begin   // next center starts clean
                acc_count <= '0;
                acc_mask  <= '0;
            end else if (scan_en) begin
                acc_count <= acc_count + hit;
                acc_mask  <= acc_mask | hit_bit;
            end
        end
    end

    // final point of the center folded in here
    always_ff @(posedge CLK) begin
        if (last_point) begin
            result_count <= acc_count + hit;
            result_mask  <= acc_mask | hit_bit;
            result_x     <= cx;
            result_y     <= cy;
        end
    end

    a_count_bound: assert property (
        @(posedge CLK) disable iff (RST)
        result_valid |-> (result_count <= N_POINTS)
    ) else $error("covered count %0d exceeds point count", result_count);

endmodule

// File: logic/laser_ctrl.sv
`timescale 1ns/1ps

module laser_ctrl #(
    parameter int N_POINTS = 40
) (
    input  logic              CLK,
    input  logic              RST,
    input  logic              in_valid,
    output logic              wr_en,
    output laser_pkg::count_t point_idx,
    output logic              scan_en,
    output logic              second_pass,
    output logic              last_point,
    output laser_pkg::coord_t cx,
    output laser_pkg::coord_t cy,
    output logic              pass_end
);

    localparam laser_pkg::count_t LAST_IDX = laser_pkg::count_t'(N_POINTS - 1);

    laser_pkg::ctrl_state_t state;
    laser_pkg::ctrl_state_t state_nxt;

    logic in_pass;
    logic drain;         // cycle after the final center, last result in flight
    logic idx_wrap;
    logic last_center;

    assign in_pass     = (state == laser_pkg::PASS1) || (state == laser_pkg::PASS2);
    assign wr_en       = (state == laser_pkg::LOAD) && in_valid;
    assign scan_en     = in_pass && !drain && !pass_end;
    assign second_pass = (state == laser_pkg::PASS2);
    assign idx_wrap    = (point_idx == LAST_IDX);
    assign last_point  = scan_en && idx_wrap;
    assign last_center = (cx == laser_pkg::GRID_MAX) && (cy == laser_pkg::GRID_MAX);

    always_comb begin
        state_nxt = state;
        case (state)
            laser_pkg::IDLE: begin
                state_nxt = laser_pkg::LOAD;
            end
            laser_pkg::LOAD: begin
                if (wr_en && idx_wrap) begin
                    state_nxt = laser_pkg::PASS1;
                end
            end
            laser_pkg::PASS1: begin
                if (pass_end) begin
                    state_nxt = laser_pkg::PASS2;
                end
            end
            laser_pkg::PASS2: begin
                if (pass_end) begin
                    state_nxt = laser_pkg::REPORT;
                end
            end
            laser_pkg::REPORT: begin
                state_nxt = laser_pkg::LOAD;   // next job, no reset needed
            end
            default: begin
                state_nxt = laser_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            state     <= laser_pkg::IDLE;
            point_idx <= '0;
            cx        <= '0;
            cy        <= '0;
            drain     <= 1'b0;
            pass_end  <= 1'b0;
        end else begin
            state    <= state_nxt;
            drain    <= last_point && last_center;
            pass_end <= drain;

            // one index counter serves both loading and scanning
            if (wr_en || scan_en) begin
                point_idx <= idx_wrap ? '0 : point_idx + 1'b1;
            end

            if (last_point) begin   // x fastest, row by row
                cx <= (cx == laser_pkg::GRID_MAX) ? '0 : cx + 1'b1;
                if (cx == laser_pkg::GRID_MAX) begin
                    cy <= (cy == laser_pkg::GRID_MAX) ? '0 : cy + 1'b1;
                end
            end
        end
    end

    // host only loads between jobs
    a_no_strobe_in_scan: assert property (
        @(posedge CLK) disable iff (RST)
        in_pass |-> !in_valid
    ) else $error("in_valid strobe arrived during a search pass");

endmodule

// File: logic/laser_pkg.sv
package laser_pkg;

    // grid coordinates, 0..15 on both axes
    localparam int COORD_W = 4;

    typedef logic [COORD_W-1:0] coord_t;

    localparam coord_t GRID_MAX = coord_t'(15);

    // point counts and point indices, up to 63 points per job
    localparam int CNT_W = 6;

    typedef logic [CNT_W-1:0] count_t;

    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        LOAD   = 3'd1,
        PASS1  = 3'd2,   // search for circle one
        PASS2  = 3'd3,   // search for circle two, circle one points excluded
        REPORT = 3'd4
    } ctrl_state_t;

endpackage

// File: logic/laser_top.sv
`timescale 1ns/1ps

module laser_top #(
    parameter int N_POINTS = 40
) (
    input  logic              CLK,
    input  logic              RST,
    input  logic              in_valid,
    input  laser_pkg::coord_t x,
    input  laser_pkg::coord_t y,
    output laser_pkg::coord_t c1_x,
    output laser_pkg::coord_t c1_y,
    output laser_pkg::coord_t c2_x,
    output laser_pkg::coord_t c2_y,
    output logic              done
);

    logic                wr_en;
    laser_pkg::count_t   point_idx;
    logic                scan_en;
    logic                second_pass;
    logic                last_point;
    logic                pass_end;
    laser_pkg::coord_t   cx;
    laser_pkg::coord_t   cy;
    laser_pkg::coord_t   px;
    laser_pkg::coord_t   py;
    logic [N_POINTS-1:0] c1_mask;

    logic                result_valid;
    laser_pkg::count_t   result_count;
    logic [N_POINTS-1:0] result_mask;
    laser_pkg::coord_t   result_x;
    laser_pkg::coord_t   result_y;

    laser_ctrl #(
        .N_POINTS (N_POINTS)
    ) u_ctrl (
        .CLK         (CLK),
        .RST         (RST),
        .in_valid    (in_valid),
        .wr_en       (wr_en),
        .point_idx   (point_idx),
        .scan_en     (scan_en),
        .second_pass (second_pass),
        .last_point  (last_point),
        .cx          (cx),
        .cy          (cy),
        .pass_end    (pass_end)
    );

    point_store #(
        .N_POINTS (N_POINTS)
    ) u_store (
        .CLK       (CLK),
        .wr_en     (wr_en),
        .point_idx (point_idx),
        .x         (x),
        .y         (y),
        .px        (px),
        .py        (py)
    );

    cover_counter #(
        .N_POINTS (N_POINTS)
    ) u_count (
        .CLK          (CLK),
        .RST          (RST),
        .scan_en      (scan_en),
        .second_pass  (second_pass),
        .last_point   (last_point),
        .point_idx    (point_idx),
        .cx           (cx),
        .cy           (cy),
        .px           (px),
        .py           (py),
        .c1_mask      (c1_mask),
        .result_valid (result_valid),
        .result_count (result_count),
        .result_mask  (result_mask),
        .result_x     (result_x),
        .result_y     (result_y)
    );

    best_select #(
        .N_POINTS (N_POINTS)
    ) u_best (
        .CLK          (CLK),
        .RST          (RST),
        .result_valid (result_valid),
        .result_count (result_count),
        .result_mask  (result_mask),
        .result_x     (result_x),
        .result_y     (result_y),
        .second_pass  (second_pass),
        .pass_end     (pass_end),
        .c1_mask      (c1_mask),
        .c1_x         (c1_x),
        .c1_y         (c1_y),
        .c2_x         (c2_x),
        .c2_y         (c2_y),
        .done         (done)
    );

endmodule

// File: logic/point_store.sv
`timescale 1ns/1ps

module point_store #(
    parameter int N_POINTS = 40
) (
    input  logic              CLK,
    input  logic              wr_en,
    input  laser_pkg::count_t point_idx,
    input  laser_pkg::coord_t x,
    input  laser_pkg::coord_t y,
    output laser_pkg::coord_t px,
    output laser_pkg::coord_t py
);

    laser_pkg::coord_t mem_x [N_POINTS];
    laser_pkg::coord_t mem_y [N_POINTS];

    always_ff @(posedge CLK) begin
        if (wr_en) begin
            mem_x[point_idx] <= x;
            mem_y[point_idx] <= y;
        end
    end

    // read port shares the index with the write port
    assign px = mem_x[point_idx];
    assign py = mem_y[point_idx];

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run, pass only when the pass line shows up in the output
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f src.f --top-module laser_tb -o laser_sim &&
./obj_dir/laser_sim | tee /dev/stderr | grep -qF "Test completed successfully" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: include/laser_tb_cases.svh
`ifndef LASER_TB_CASES_SVH
`define LASER_TB_CASES_SVH

typedef enum logic [2:0] {
    PAT_CLUSTER      = 3'd0,   // points spread a little around base
    PAT_TWO_CLUSTERS = 3'd1,   // base and its mirror (15 - x, 15 - y)
    PAT_CORNERS      = 3'd2,   // four grid corners, base unused
    PAT_SAME_SPOT    = 3'd3,   // every point on base
    PAT_RANDOM       = 3'd4    // whole grid, base unused
} pattern_kind_t;

typedef struct packed {
    pattern_kind_t     kind;
    laser_pkg::coord_t base_x;
    laser_pkg::coord_t base_y;
    logic [3:0]        max_gap;   // idle cycles between strobes, up to this
} tb_case_t;

localparam int N_CASES = 9;

localparam tb_case_t TB_CASES [N_CASES] = '{
    '{PAT_CLUSTER,      4'd5,  4'd6,  4'd0},
    '{PAT_CLUSTER,      4'd12, 4'd3,  4'd2},
    '{PAT_TWO_CLUSTERS, 4'd2,  4'd3,  4'd1},
    '{PAT_TWO_CLUSTERS, 4'd4,  4'd11, 4'd0},
    '{PAT_CORNERS,      4'd0,  4'd0,  4'd1},
    '{PAT_SAME_SPOT,    4'd7,  4'd9,  4'd0},
    '{PAT_RANDOM,       4'd0,  4'd0,  4'd3},
    '{PAT_RANDOM,       4'd0,  4'd0,  4'd5},
    '{PAT_RANDOM,       4'd0,  4'd0,  4'd0}
};

`endif

// File: sim/laser_tb.sv
`timescale 1ns/1ps

module laser_tb;

    `include "laser_tb_cases.svh"

    localparam int     N_POINTS    = 40;
    localparam int     JOB_CYCLES  = 2 * (256 * N_POINTS + 1) + 2;   // last strobe to done
    localparam longint WATCHDOG_NS = longint'(N_CASES) * 25000 * 20;

    logic              CLK;
    logic              RST;
    logic              in_valid;
    laser_pkg::coord_t x;
    laser_pkg::coord_t y;
    laser_pkg::coord_t c1_x;
    laser_pkg::coord_t c1_y;
    laser_pkg::coord_t c2_x;
    laser_pkg::coord_t c2_y;
    logic              done;

    laser_pkg::coord_t pts_x [N_POINTS];
    laser_pkg::coord_t pts_y [N_POINTS];
    int                errors;
    int                passed;

    laser_top #(
        .N_POINTS (N_POINTS)
    ) u_dut (
        .CLK      (CLK),
        .RST      (RST),
        .in_valid (in_valid),
        .x        (x),
        .y        (y),
        .c1_x     (c1_x),
        .c1_y     (c1_y),
        .c2_x     (c2_x),
        .c2_y     (c2_y),
        .done     (done)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, done never came for the running job");
        $display("Test failed");
        $finish;
    end

    // offset of up to spread around base, kept on the grid
    function automatic laser_pkg::coord_t near(input int base, input int spread);
        int v;
        v = base + int'($urandom % (2 * spread + 1)) - spread;
        if (v < 0) v = 0;
        if (v > 15) v = 15;
        return laser_pkg::coord_t'(v);
    endfunction

    task automatic make_points(input tb_case_t tc);
        int c;
        for (int i = 0; i < N_POINTS; i++) begin
            c = i % 4;
            case (tc.kind)
                PAT_CLUSTER: begin
                    pts_x[i] = near(tc.base_x, 2);
                    pts_y[i] = near(tc.base_y, 2);
                end
                PAT_TWO_CLUSTERS: begin
                    pts_x[i] = near((i % 2) ? 15 - tc.base_x : tc.base_x, 1);
                    pts_y[i] = near((i % 2) ? 15 - tc.base_y : tc.base_y, 1);
                end
                PAT_CORNERS: begin
                    pts_x[i] = (c & 1) ? near(14, 1) : near(1, 1);
                    pts_y[i] = (c & 2) ? near(14, 1) : near(1, 1);
                end
                PAT_SAME_SPOT: begin
                    pts_x[i] = tc.base_x;
                    pts_y[i] = tc.base_y;
                end
                default: begin
                    pts_x[i] = laser_pkg::coord_t'($urandom % 16);
                    pts_y[i] = laser_pkg::coord_t'($urandom % 16);
                end
            endcase
        end
    endtask

    // squared distance at most 16
    function automatic bit covers(input int cx, input int cy, input int px, input int py);
        return ((cx - px) * (cx - px) + (cy - py) * (cy - py)) <= 16;
    endfunction

    // greedy two-pass search, row by row, strictly greater replaces
    task automatic run_model(output int e1x, output int e1y, output int e2x, output int e2y);
        bit taken [N_POINTS];
        int best;
        int cnt;
        best = -1;
        for (int cy = 0; cy < 16; cy++) begin
            for (int cx = 0; cx < 16; cx++) begin
                cnt = 0;
                for (int i = 0; i < N_POINTS; i++)
                    if (covers(cx, cy, pts_x[i], pts_y[i])) cnt++;
                if (cnt > best) begin
                    best = cnt;
                    e1x  = cx;
                    e1y  = cy;
                end
            end
        end
        for (int i = 0; i < N_POINTS; i++)
            taken[i] = covers(e1x, e1y, pts_x[i], pts_y[i]);
        best = -1;
        for (int cy = 0; cy < 16; cy++) begin
            for (int cx = 0; cx < 16; cx++) begin
                cnt = 0;
                for (int i = 0; i < N_POINTS; i++)
                    if (!taken[i] && covers(cx, cy, pts_x[i], pts_y[i])) cnt++;
                if (cnt > best) begin
                    best = cnt;
                    e2x  = cx;
                    e2y  = cy;
                end
            end
        end
    endtask

    task automatic load_points(input int max_gap);
        int gap;
        for (int i = 0; i < N_POINTS; i++) begin
            @(posedge CLK);
            in_valid <= 1'b1;
            x        <= pts_x[i];
            y        <= pts_y[i];
            gap = (i == N_POINTS - 1) ? 0 : int'($urandom % (max_gap + 1));
            repeat (gap) begin
                @(posedge CLK);
                in_valid <= 1'b0;
            end
        end
        @(posedge CLK);
        in_valid <= 1'b0;   // edge that takes the final point
    endtask

    task automatic compare_center(input string name, input laser_pkg::coord_t gx,
                                  input laser_pkg::coord_t gy, input int ex, input int ey);
        if (gx !== laser_pkg::coord_t'(ex) || gy !== laser_pkg::coord_t'(ey)) begin
            $display("FAIL %0t: %s is (%0d,%0d), expected (%0d,%0d)", $time, name, gx, gy, ex, ey);
            errors++;
        end
    endtask

    initial begin
        tb_case_t          tc;
        int                e1x, e1y, e2x, e2y;
        int                errs_before;
        int                cycles;
        bit                moved;
        laser_pkg::coord_t prev [4];

        void'($urandom(35));
        RST      = 1'b1;
        in_valid = 1'b0;
        x        = '0;
        y        = '0;
        errors   = 0;
        passed   = 0;
        prev     = '{default: '0};
        repeat (2) @(posedge CLK);
        RST <= 1'b0;
        @(negedge CLK);
        if (done !== 1'b0 || {c1_x, c1_y, c2_x, c2_y} !== '0) begin
            $display("FAIL %0t: outputs not cleared after reset", $time);
            errors++;
        end

        for (int t = 0; t < N_CASES; t++) begin
            tc          = TB_CASES[t];
            errs_before = errors;
            make_points(tc);
            run_model(e1x, e1y, e2x, e2y);
            load_points(tc.max_gap);
            cycles = 0;
            moved  = 1'b0;
            @(negedge CLK);
            while (done !== 1'b1) begin
                if (c1_x !== prev[0] || c1_y !== prev[1] || c2_x !== prev[2] || c2_y !== prev[3])
                    moved = 1'b1;
                cycles++;
                @(negedge CLK);
            end
            if (moved) begin
                $display("FAIL %0t: outputs changed before done in test %0d", $time, t);
                errors++;
            end
            if (cycles != JOB_CYCLES) begin
                $display("FAIL %0t: done after %0d cycles, expected %0d", $time, cycles, JOB_CYCLES);
                errors++;
            end
            compare_center("circle one", c1_x, c1_y, e1x, e1y);
            compare_center("circle two", c2_x, c2_y, e2x, e2y);
            if (tc.kind == PAT_SAME_SPOT)
                compare_center("circle two, nothing left", c2_x, c2_y, 0, 0);
            prev = '{c1_x, c1_y, c2_x, c2_y};
            @(negedge CLK);
            if (done !== 1'b0) begin
                $display("FAIL %0t: done longer than one cycle in test %0d", $time, t);
                errors++;
            end
            if (errors == errs_before) passed++;
            $display("test %0d kind %0d: c1=(%0d,%0d) c2=(%0d,%0d) %s", t, tc.kind,
                     prev[0], prev[1], prev[2], prev[3], (errors == errs_before) ? "ok" : "bad");
        end

        $display("tests %0d, passed %0d, failed %0d, failed checks %0d",
                 N_CASES, passed, N_CASES - passed, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+include
logic/laser_pkg.sv
logic/point_store.sv
logic/cover_counter.sv
logic/best_select.sv
logic/laser_ctrl.sv
logic/laser_top.sv
sim/laser_tb.sv
